/* Bender.yml */
package:
  name: cluster_periph

sources:
  - src/cluster_periph_pkg.sv
  - src/periph_decoder.sv
  - src/cluster_ctrl_unit.sv
  - src/cluster_timer.sv
  - src/event_unit.sv
  - src/cluster_periph_top.sv
  - target: simulation
    files:
      - verif/tb_clk_gen.sv
      - verif/cluster_periph_assertions.sv
      - verif/tb_cluster_periph.sv

/* cluster_periph.f */
src/cluster_periph_pkg.sv
src/periph_decoder.sv
src/cluster_ctrl_unit.sv
src/cluster_timer.sv
src/event_unit.sv
src/cluster_periph_top.sv
verif/tb_clk_gen.sv
verif/cluster_periph_assertions.sv
verif/tb_cluster_periph.sv

/* src/cluster_ctrl_unit.sv */
// cluster control registers
`timescale 1ns/1ps
`default_nettype none

module cluster_ctrl_unit
  import cluster_periph_pkg::*;
#(
  parameter int unsigned NB_CORES  = 4,
  parameter logic [31:0] BOOT_ADDR = 32'h1C00_0000
) (
  input  wire logic               clk_i,
  input  wire logic               rst_n_i,
  input  wire periph_req_t        req_i,
  output periph_rsp_t             rsp_o,
  output logic                    eoc_o,
  output logic [NB_CORES-1:0]     fetch_enable_o,
  output logic [NB_CORES-1:0][31:0] boot_addr_o
);

  logic                       eoc_q;
  logic [NB_CORES-1:0]        fetch_en_q;
  logic [NB_CORES-1:0][31:0]  boot_addr_q;
  logic                       r_valid_q;
  logic [3:0]                 r_id_q;
  logic [31:0]                r_rdata_q;
  logic [OFS_W-1:0]           ofs;
  logic [1:0]                 boot_idx;
  logic                       boot_hit;
  logic                       wr_en;
  logic [31:0]                rd_data;
  logic [31:0]                wr_val;

  assign ofs      = req_i.addr[OFS_W-1:0];
  assign wr_en    = req_i.req & ~req_i.wen;
  assign boot_idx = ofs[3:2];
  // one boot address word per core starting at the base offset
  assign boot_hit = (ofs[OFS_W-1:4] == BOOT_ADDR_BASE_OFS[OFS_W-1:4]) &&
                    (int'(boot_idx) < NB_CORES);

  always_comb begin
    rd_data = '0;
    if (ofs == EOC_OFS) begin
      rd_data[0] = eoc_q;
    end else if (ofs == FETCH_EN_OFS) begin
      rd_data[NB_CORES-1:0] = fetch_en_q;
    end else if (boot_hit) begin
      rd_data = boot_addr_q[boot_idx];
    end
  end

  assign wr_val = be_merge(rd_data, req_i.wdata, req_i.be);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      eoc_q       <= 1'b0;
      fetch_en_q  <= '0;
      boot_addr_q <= {NB_CORES{BOOT_ADDR}};
      r_valid_q   <= 1'b0;
    end else begin
      r_valid_q <= req_i.req;
      if (wr_en) begin
        if (ofs == EOC_OFS) begin
          eoc_q <= wr_val[0];
        end else if (ofs == FETCH_EN_OFS) begin
          fetch_en_q <= wr_val[NB_CORES-1:0];
        end else if (boot_hit) begin
          boot_addr_q[boot_idx] <= wr_val;
        end
      end
    end
  end

  // response payload is valid only with r_valid
  always_ff @(posedge clk_i) begin
    if (req_i.req) begin
      r_id_q    <= req_i.id;
      r_rdata_q <= req_i.wen ? rd_data : '0;
    end
  end

  assign rsp_o.gnt     = req_i.req;
  assign rsp_o.r_valid = r_valid_q;
  assign rsp_o.r_rdata = r_rdata_q;
  assign rsp_o.r_id    = r_id_q;

  assign eoc_o          = eoc_q;
  assign fetch_enable_o = fetch_en_q;
  assign boot_addr_o    = boot_addr_q;

endmodule

`default_nettype wire

/* src/cluster_periph_pkg.sv */
// cluster peripheral definitions
`default_nettype none

package cluster_periph_pkg;

  // ************************************************************************
  // bus widths and structs
  // ************************************************************************

  localparam int unsigned ADDR_W = 12;
  // offset bits seen by a target sit below the target select bits
  localparam int unsigned OFS_W  = 10;

  typedef struct packed {
    logic              req;
    logic [ADDR_W-1:0] addr;
    // high means read
    logic              wen;
    logic [31:0]       wdata;
    logic [3:0]        be;
    logic [3:0]        id;
  } periph_req_t;

  typedef struct packed {
    logic        gnt;
    logic        r_valid;
    logic [31:0] r_rdata;
    logic [3:0]  r_id;
  } periph_rsp_t;

  // target select taken from addr[11:10]
  typedef enum logic [1:0] {
    TGT_CTRL  = 2'd0,
    TGT_TIMER = 2'd1,
    TGT_EU    = 2'd2,
    TGT_DMA   = 2'd3
  } tgt_sel_e;

  // ************************************************************************
  // register map
  // ************************************************************************

  localparam logic [OFS_W-1:0] EOC_OFS            = 10'h000;
  localparam logic [OFS_W-1:0] FETCH_EN_OFS       = 10'h004;
  localparam logic [OFS_W-1:0] BOOT_ADDR_BASE_OFS = 10'h040;

  localparam logic [OFS_W-1:0] TIMER_CFG_OFS = 10'h000;
  localparam logic [OFS_W-1:0] TIMER_CNT_OFS = 10'h008;
  localparam logic [OFS_W-1:0] TIMER_CMP_OFS = 10'h010;

  // event unit register kind in addr[5:4], core index in addr[3:2]
  localparam logic [1:0] EU_MASK_KIND   = 2'd0;
  localparam logic [1:0] EU_BUF_KIND    = 2'd1;
  localparam logic [1:0] EU_SW_SET_KIND = 2'd2;
  localparam logic [1:0] EU_CLR_KIND    = 2'd3;

  // event sources per core; bit 3 is the software event
  localparam int unsigned EVT_SRC_NUM   = 4;
  localparam int unsigned EVT_ID_W      = 2;
  localparam int unsigned EVT_TIMER_BIT = 0;
  localparam int unsigned EVT_DMA_BIT   = 1;
  localparam int unsigned EVT_HWPE_BIT  = 2;

  // byte-enable merge of write data into the current register value
  function automatic logic [31:0] be_merge(logic [31:0] old_val, logic [31:0] new_val,
                                           logic [3:0] be);
    logic [31:0] res;
    res = old_val;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) begin
        res[8*b +: 8] = new_val[8*b +: 8];
      end
    end
    return res;
  endfunction

endpackage

`default_nettype wire

/* src/cluster_periph_top.sv */
// cluster peripheral subsystem
`timescale 1ns/1ps
`default_nettype none

module cluster_periph_top
  import cluster_periph_pkg::*;
#(
  parameter int unsigned NB_CORES  = 4,
  parameter logic [31:0] BOOT_ADDR = 32'h1C00_0000
) (
  input  wire logic                         clk_i,
  input  wire logic                         rst_n_i,

  input  wire periph_req_t                  bus_req_i,
  output periph_rsp_t                       bus_rsp_o,

  output periph_req_t                       dma_req_o,
  input  wire periph_rsp_t                  dma_rsp_i,

  input  wire logic                         dma_evt_i,
  input  wire logic [NB_CORES-1:0]          hwpe_evt_i,

  input  wire logic [NB_CORES-1:0]          irq_ack_i,
  output logic [NB_CORES-1:0]               irq_req_o,
  output logic [NB_CORES-1:0][EVT_ID_W-1:0] irq_id_o,

  output logic                              eoc_o,
  output logic [NB_CORES-1:0]               fetch_enable_o,
  output logic [NB_CORES-1:0][31:0]         boot_addr_o,
  output logic                              busy_o
);

  periph_req_t ctrl_req;
  periph_rsp_t ctrl_rsp;
  periph_req_t timer_req;
  periph_rsp_t timer_rsp;
  periph_req_t eu_req;
  periph_rsp_t eu_rsp;
  logic        timer_evt;

  // ************************************************************************
  // bus decoder
  // ************************************************************************

  periph_decoder i_periph_decoder (
    .clk_i       ( clk_i     ),
    .rst_n_i     ( rst_n_i   ),
    .bus_req_i   ( bus_req_i ),
    .bus_rsp_o   ( bus_rsp_o ),
    .ctrl_req_o  ( ctrl_req  ),
    .ctrl_rsp_i  ( ctrl_rsp  ),
    .timer_req_o ( timer_req ),
    .timer_rsp_i ( timer_rsp ),
    .eu_req_o    ( eu_req    ),
    .eu_rsp_i    ( eu_rsp    ),
    .dma_req_o   ( dma_req_o ),
    .dma_rsp_i   ( dma_rsp_i )
  );

  // ************************************************************************
  // targets
  // ************************************************************************

  cluster_ctrl_unit #(
    .NB_CORES  ( NB_CORES  ),
    .BOOT_ADDR ( BOOT_ADDR )
  ) i_cluster_ctrl_unit (
    .clk_i          ( clk_i          ),
    .rst_n_i        ( rst_n_i        ),
    .req_i          ( ctrl_req       ),
    .rsp_o          ( ctrl_rsp       ),
    .eoc_o          ( eoc_o          ),
    .fetch_enable_o ( fetch_enable_o ),
    .boot_addr_o    ( boot_addr_o    )
  );

  cluster_timer i_cluster_timer (
    .clk_i       ( clk_i     ),
    .rst_n_i     ( rst_n_i   ),
    .req_i       ( timer_req ),
    .rsp_o       ( timer_rsp ),
    .timer_evt_o ( timer_evt ),
    .busy_o      ( busy_o    )
  );

  // timer and dma events fan out to every core inside
  event_unit #(
    .NB_CORES ( NB_CORES )
  ) i_event_unit (
    .clk_i       ( clk_i      ),
    .rst_n_i     ( rst_n_i    ),
    .req_i       ( eu_req     ),
    .rsp_o       ( eu_rsp     ),
    .timer_evt_i ( timer_evt  ),
    .dma_evt_i   ( dma_evt_i  ),
    .hwpe_evt_i  ( hwpe_evt_i ),
    .irq_ack_i   ( irq_ack_i  ),
    .irq_req_o   ( irq_req_o  ),
    .irq_id_o    ( irq_id_o   )
  );

endmodule

`default_nettype wire

/* src/cluster_timer.sv */
// cluster cycle timer
`timescale 1ns/1ps
`default_nettype none

module cluster_timer
  import cluster_periph_pkg::*;
(
  input  wire logic        clk_i,
  input  wire logic        rst_n_i,
  input  wire periph_req_t req_i,
  output periph_rsp_t      rsp_o,
  output logic             timer_evt_o,
  output logic             busy_o
);

  // cfg bit 0 enables counting, bit 1 clears the count on match
  logic [1:0]       cfg_q;
  logic [31:0]      cnt_q;
  logic [31:0]      cmp_q;
  logic             evt_q;
  logic             match;
  logic             r_valid_q;
  logic [3:0]       r_id_q;
  logic [31:0]      r_rdata_q;
  logic [OFS_W-1:0] ofs;
  logic             wr_en;
  logic [31:0]      rd_data;
  logic [31:0]      wr_val;

  assign ofs   = req_i.addr[OFS_W-1:0];
  assign wr_en = req_i.req & ~req_i.wen;
  assign match = cfg_q[0] && (cnt_q == cmp_q);

  always_comb begin
    case (ofs)
      TIMER_CFG_OFS: rd_data = {30'b0, cfg_q};
      TIMER_CNT_OFS: rd_data = cnt_q;
      TIMER_CMP_OFS: rd_data = cmp_q;
      default:       rd_data = '0;
    endcase
  end

  assign wr_val = be_merge(rd_data, req_i.wdata, req_i.be);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      cfg_q     <= '0;
      cnt_q     <= '0;
      cmp_q     <= '0;
      evt_q     <= 1'b0;
      r_valid_q <= 1'b0;
    end else begin
      r_valid_q <= req_i.req;
      evt_q     <= match;
      if (cfg_q[0]) begin
        cnt_q <= (match && cfg_q[1]) ? '0 : cnt_q + 32'd1;
      end
      // a bus write wins over the count update
      if (wr_en) begin
        case (ofs)
          TIMER_CFG_OFS: cfg_q <= wr_val[1:0];
          TIMER_CNT_OFS: cnt_q <= wr_val;
          TIMER_CMP_OFS: cmp_q <= wr_val;
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_i.req) begin
      r_id_q    <= req_i.id;
      r_rdata_q <= req_i.wen ? rd_data : '0;
    end
  end

  assign rsp_o.gnt     = req_i.req;
  assign rsp_o.r_valid = r_valid_q;
  assign rsp_o.r_rdata = r_rdata_q;
  assign rsp_o.r_id    = r_id_q;

  assign timer_evt_o = evt_q;
  assign busy_o      = cfg_q[0];

endmodule

`default_nettype wire

/* src/event_unit.sv */
// per-core event unit
`timescale 1ns/1ps
`default_nettype none

module event_unit
  import cluster_periph_pkg::*;
#(
  parameter int unsigned NB_CORES = 4
) (
  input  wire logic                      clk_i,
  input  wire logic                      rst_n_i,
  input  wire periph_req_t               req_i,
  output periph_rsp_t                    rsp_o,
  input  wire logic                      timer_evt_i,
  input  wire logic                      dma_evt_i,
  input  wire logic [NB_CORES-1:0]       hwpe_evt_i,
  input  wire logic [NB_CORES-1:0]       irq_ack_i,
  output logic [NB_CORES-1:0]            irq_req_o,
  output logic [NB_CORES-1:0][EVT_ID_W-1:0] irq_id_o
);

  typedef enum logic [1:0] {
    HS_IDLE,
    HS_REQ,
    HS_WAIT
  } hs_state_e;

  logic [NB_CORES-1:0][EVT_SRC_NUM-1:0] buf_q;
  logic [NB_CORES-1:0][EVT_SRC_NUM-1:0] buf_d;
  logic [NB_CORES-1:0][EVT_SRC_NUM-1:0] mask_q;
  logic [NB_CORES-1:0][EVT_SRC_NUM-1:0] evt_in;
  logic [NB_CORES-1:0][EVT_ID_W-1:0]    id_q;
  hs_state_e                            hs_q [NB_CORES];
  logic                                 r_valid_q;
  logic [3:0]                           r_id_q;
  logic [31:0]                          r_rdata_q;
  logic [OFS_W-1:0]                     ofs;
  logic [1:0]                           kind;
  logic [1:0]                           core_idx;
  logic                                 core_ok;
  logic                                 wr_en;
  logic [31:0]                          rd_data;
  logic [31:0]                          wr_val;

  // lowest pending source wins
  function automatic logic [EVT_ID_W-1:0] lowest_id(logic [EVT_SRC_NUM-1:0] vec);
    logic [EVT_ID_W-1:0] idx;
    idx = '0;
    for (int i = EVT_SRC_NUM - 1; i >= 0; i--) begin
      if (vec[i]) begin
        idx = EVT_ID_W'(i);
      end
    end
    return idx;
  endfunction

  assign ofs      = req_i.addr[OFS_W-1:0];
  assign kind     = ofs[5:4];
  assign core_idx = ofs[3:2];
  assign core_ok  = int'(core_idx) < NB_CORES;
  assign wr_en    = req_i.req & ~req_i.wen & core_ok;

  always_comb begin
    rd_data = '0;
    if (core_ok && kind == EU_MASK_KIND) begin
      rd_data[EVT_SRC_NUM-1:0] = mask_q[core_idx];
    end else if (core_ok && kind == EU_BUF_KIND) begin
      rd_data[EVT_SRC_NUM-1:0] = buf_q[core_idx];
    end
  end

  assign wr_val = be_merge(rd_data, req_i.wdata, req_i.be);

  // ************************************************************************
  // event buffers
  // ************************************************************************

  always_comb begin
    buf_d = buf_q;
    for (int c = 0; c < NB_CORES; c++) begin
      evt_in[c]                = '0;
      evt_in[c][EVT_TIMER_BIT] = timer_evt_i;
      evt_in[c][EVT_DMA_BIT]   = dma_evt_i;
      evt_in[c][EVT_HWPE_BIT]  = hwpe_evt_i[c];
      // acked bit drops on the edge that lowers irq_req
      if (hs_q[c] == HS_REQ && irq_ack_i[c]) begin
        buf_d[c][id_q[c]] = 1'b0;
      end
      buf_d[c] = buf_d[c] | evt_in[c];
      if (wr_en && int'(core_idx) == c) begin
        case (kind)
          EU_BUF_KIND:    buf_d[c] = wr_val[EVT_SRC_NUM-1:0];
          EU_SW_SET_KIND: buf_d[c] = buf_d[c] | wr_val[EVT_SRC_NUM-1:0];
          EU_CLR_KIND:    buf_d[c] = buf_d[c] & ~wr_val[EVT_SRC_NUM-1:0];
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      buf_q     <= '0;
      mask_q    <= '0;
      r_valid_q <= 1'b0;
    end else begin
      buf_q     <= buf_d;
      r_valid_q <= req_i.req;
      if (wr_en && kind == EU_MASK_KIND) begin
        mask_q[core_idx] <= wr_val[EVT_SRC_NUM-1:0];
      end
    end
  end

  // ************************************************************************
  // four-phase interrupt handshake
  // ************************************************************************

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      for (int c = 0; c < NB_CORES; c++) begin
        hs_q[c] <= HS_IDLE;
      end
      id_q <= '0;
    end else begin
      for (int c = 0; c < NB_CORES; c++) begin
        case (hs_q[c])
          HS_IDLE: begin
            if (|(buf_q[c] & mask_q[c])) begin
              hs_q[c] <= HS_REQ;
              id_q[c] <= lowest_id(buf_q[c] & mask_q[c]);
            end
          end
          HS_REQ: begin
            if (irq_ack_i[c]) begin
              hs_q[c] <= HS_WAIT;
            end
          end
          HS_WAIT: begin
            // ack must be seen low before the next request
            if (!irq_ack_i[c]) begin
              hs_q[c] <= HS_IDLE;
            end
          end
          default: hs_q[c] <= HS_IDLE;
        endcase
      end
    end
  end

  always_comb begin
    for (int c = 0; c < NB_CORES; c++) begin
      irq_req_o[c] = (hs_q[c] == HS_REQ);
    end
  end

  assign irq_id_o = id_q;

  always_ff @(posedge clk_i) begin
    if (req_i.req) begin
      r_id_q    <= req_i.id;
      r_rdata_q <= req_i.wen ? rd_data : '0;
    end
  end

  assign rsp_o.gnt     = req_i.req;
  assign rsp_o.r_valid = r_valid_q;
  assign rsp_o.r_rdata = r_rdata_q;
  assign rsp_o.r_id    = r_id_q;

endmodule

`default_nettype wire

/* src/periph_decoder.sv */
// peripheral bus decoder
`timescale 1ns/1ps
`default_nettype none

module periph_decoder
  import cluster_periph_pkg::*;
(
  input  wire logic        clk_i,
  input  wire logic        rst_n_i,

  input  wire periph_req_t bus_req_i,
  output periph_rsp_t      bus_rsp_o,

  output periph_req_t      ctrl_req_o,
  input  wire periph_rsp_t ctrl_rsp_i,
  output periph_req_t      timer_req_o,
  input  wire periph_rsp_t timer_rsp_i,
  output periph_req_t      eu_req_o,
  input  wire periph_rsp_t eu_rsp_i,
  output periph_req_t      dma_req_o,
  input  wire periph_rsp_t dma_rsp_i
);

  tgt_sel_e    sel;
  tgt_sel_e    tgt_q;
  logic        busy_q;
  logic        fwd_req;
  logic        rsp_gnt;
  logic        rsp_valid;
  logic        grant;
  periph_rsp_t sel_rsp;
  periph_rsp_t q_rsp;

  function automatic periph_rsp_t pick_rsp(tgt_sel_e t, periph_rsp_t c, periph_rsp_t tm,
                                           periph_rsp_t eu, periph_rsp_t dma);
    case (t)
      TGT_CTRL:  return c;
      TGT_TIMER: return tm;
      TGT_EU:    return eu;
      default:   return dma;
    endcase
  endfunction

  assign sel = tgt_sel_e'(bus_req_i.addr[ADDR_W-1:ADDR_W-2]);

  // only one transaction in flight, so nothing is forwarded while busy
  assign fwd_req = bus_req_i.req & ~busy_q;

  always_comb begin
    ctrl_req_o      = bus_req_i;
    timer_req_o     = bus_req_i;
    eu_req_o        = bus_req_i;
    dma_req_o       = bus_req_i;
    ctrl_req_o.req  = fwd_req & (sel == TGT_CTRL);
    timer_req_o.req = fwd_req & (sel == TGT_TIMER);
    eu_req_o.req    = fwd_req & (sel == TGT_EU);
    dma_req_o.req   = fwd_req & (sel == TGT_DMA);
  end

  // gnt comes from the addressed target, response from the remembered one
  assign sel_rsp = pick_rsp(sel, ctrl_rsp_i, timer_rsp_i, eu_rsp_i, dma_rsp_i);
  assign q_rsp   = pick_rsp(tgt_q, ctrl_rsp_i, timer_rsp_i, eu_rsp_i, dma_rsp_i);

  assign rsp_gnt   = fwd_req & sel_rsp.gnt;
  assign rsp_valid = busy_q & q_rsp.r_valid;
  assign grant     = rsp_gnt;

  always_comb begin
    bus_rsp_o         = q_rsp;
    bus_rsp_o.gnt     = rsp_gnt;
    bus_rsp_o.r_valid = rsp_valid;
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      busy_q <= 1'b0;
      tgt_q  <= TGT_CTRL;
    end else if (grant) begin
      busy_q <= 1'b1;
      tgt_q  <= sel;
    end else if (rsp_valid) begin
      busy_q <= 1'b0;
    end
  end

endmodule

`default_nettype wire

/* verif/cluster_periph_assertions.sv */
// bus and interrupt protocol assertions
`timescale 1ns/1ps
`default_nettype none

module cluster_periph_assertions
  import cluster_periph_pkg::*;
#(
  parameter int unsigned NB_CORES  = 4,
  parameter bit          CHECK_BUS = 1'b1,
  parameter bit          CHECK_IRQ = 1'b1
) (
  input wire logic                clk_i,
  input wire logic                rst_n_i,
  input wire periph_req_t         req_i,
  input wire periph_rsp_t         rsp_i,
  input wire logic [NB_CORES-1:0] irq_req_i,
  input wire logic [NB_CORES-1:0] irq_ack_i
);

  if (CHECK_BUS) begin : g_bus
    logic outstanding_q;
    logic handshake;

    assign handshake = req_i.req & rsp_i.gnt;

    // one granted transaction waiting for its r_valid
    always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
        outstanding_q <= 1'b0;
      end else if (handshake) begin
        outstanding_q <= 1'b1;
      end else if (rsp_i.r_valid) begin
        outstanding_q <= 1'b0;
      end
    end

    assert property (@(posedge clk_i) disable iff (!rst_n_i)
      req_i.req && !rsp_i.gnt |=> req_i.req && $stable(req_i))
      else $error("request dropped or changed before grant");

    assert property (@(posedge clk_i) disable iff (!rst_n_i)
      handshake |-> !outstanding_q)
      else $error("grant while a response is outstanding");

    assert property (@(posedge clk_i) disable iff (!rst_n_i)
      rsp_i.r_valid |-> outstanding_q)
      else $error("r_valid without a granted request");

    assert property (@(posedge clk_i) disable iff (!rst_n_i)
      handshake |=> ##[0:15] rsp_i.r_valid)
      else $error("granted request never answered");
  end

  if (CHECK_IRQ) begin : g_irq_chk
    for (genvar c = 0; c < NB_CORES; c++) begin : g_irq
      assert property (@(posedge clk_i) disable iff (!rst_n_i)
        irq_req_i[c] && !irq_ack_i[c] |=> irq_req_i[c])
        else $error("irq_req of core %0d dropped before ack", c);
    end
  end

endmodule

bind periph_decoder cluster_periph_assertions #(
  .CHECK_IRQ ( 1'b0 )
) i_decoder_assertions (
  .clk_i     ( clk_i     ),
  .rst_n_i   ( rst_n_i   ),
  .req_i     ( bus_req_i ),
  .rsp_i     ( bus_rsp_o ),
  .irq_req_i ( 4'b0      ),
  .irq_ack_i ( 4'b0      )
);

bind event_unit cluster_periph_assertions #(
  .NB_CORES  ( NB_CORES ),
  .CHECK_BUS ( 1'b0     )
) i_eu_assertions (
  .clk_i     ( clk_i     ),
  .rst_n_i   ( rst_n_i   ),
  .req_i     ( req_i     ),
  .rsp_i     ( rsp_o     ),
  .irq_req_i ( irq_req_o ),
  .irq_ack_i ( irq_ack_i )
);

`default_nettype wire

/* verif/cluster_periph_testdata.txt */
# op addr data expect, in hex; op w write, r read, l read below expect, e event, i irq, a ack
# e: addr 1 dma, 2 hwpe (data = core mask); i/a: addr = core; o: 0 eoc 1 fetch 2 irq 3 busy 4+c boot
o 000 00000000 00000000
o 001 00000000 00000000
o 002 00000000 00000000
o 003 00000000 00000000
r 040 00000000 1c000000
r 04c 00000000 1c000000
w 004 00000005 00000000
o 001 00000000 00000005
r 004 00000000 00000005
w 048 1c008000 00000000
o 006 00000000 1c008000
r 048 00000000 1c008000
w 000 00000001 00000000
o 000 00000000 00000001
r 000 00000000 00000001
r 020 00000000 00000000
w c04 12345678 00000000
r c08 00000000 c08a53f7
r c10 00000000 c10a53ef
r c3c 00000000 c3ca53c3
w 804 0000000c 00000000
e 002 00000002 00000000
i 001 00000002 00000000
w 824 00000008 00000000
a 001 00000000 00000000
i 001 00000003 00000000
a 001 00000000 00000000
r 814 00000000 00000000
e 002 00000004 00000000
w 828 00000008 00000000
r 818 00000000 0000000c
o 002 00000000 00000000
w 808 0000000c 00000000
i 002 00000002 00000000
a 002 00000000 00000000
i 002 00000003 00000000
a 002 00000000 00000000
w 80c 00000002 00000000
e 001 00000000 00000000
i 003 00000001 00000000
a 003 00000000 00000000
r 810 00000000 00000002
w 800 00000001 00000000
w 410 00000020 00000000
w 400 00000003 00000000
r 400 00000000 00000003
o 003 00000000 00000001
l 408 00000000 00000021
i 000 00000000 00000000
w 400 00000000 00000000
w 830 0000000f 00000000
a 000 00000000 00000000
o 002 00000000 00000000
o 003 00000000 00000000

/* verif/tb_clk_gen.sv */
// testbench clock and reset
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
  parameter real PERIOD_NS  = 4.0,
  parameter int  RST_CYCLES = 16
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2.0) clk_o = ~clk_o;
  end

  // release on a falling edge away from the sampling edge
  initial begin
    rst_n_o = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule

`default_nettype wire

/* verif/tb_cluster_periph.sv */
// cluster peripheral testbench
`timescale 1ns/1ps
`default_nettype none

module tb_cluster_periph
  import cluster_periph_pkg::*;
();

  localparam int unsigned NB_CORES     = 4;
  localparam int          CYC_PER_REC  = 200;
  localparam int          IRQ_WAIT_MAX = 100;

  logic                              clk;
  logic                              rst_n;
  periph_req_t                       bus_req;
  periph_rsp_t                       bus_rsp;
  periph_req_t                       dma_req;
  periph_rsp_t                       dma_rsp;
  logic                              dma_evt;
  logic [NB_CORES-1:0]               hwpe_evt;
  logic [NB_CORES-1:0]               irq_ack;
  logic [NB_CORES-1:0]               irq_req;
  logic [NB_CORES-1:0][EVT_ID_W-1:0] irq_id;
  logic                              eoc;
  logic [NB_CORES-1:0]               fetch_en;
  logic [NB_CORES-1:0][31:0]         boot_addr;
  logic                              busy;

  logic [7:0]  rec_op[$];
  logic [11:0] rec_addr[$];
  logic [31:0] rec_data[$];
  logic [31:0] rec_exp[$];
  int          n_checks  = 0;
  int          n_errors  = 0;
  logic        load_done = 1'b0;
  integer      seed      = 32'h277b_dcab;

  tb_clk_gen #(
    .PERIOD_NS  ( 4.0 ),
    .RST_CYCLES ( 16  )
  ) i_clk_gen (
    .clk_o   ( clk   ),
    .rst_n_o ( rst_n )
  );

  cluster_periph_top #(
    .NB_CORES ( NB_CORES )
  ) i_cluster_periph_top (
    .clk_i          ( clk       ),
    .rst_n_i        ( rst_n     ),
    .bus_req_i      ( bus_req   ),
    .bus_rsp_o      ( bus_rsp   ),
    .dma_req_o      ( dma_req   ),
    .dma_rsp_i      ( dma_rsp   ),
    .dma_evt_i      ( dma_evt   ),
    .hwpe_evt_i     ( hwpe_evt  ),
    .irq_ack_i      ( irq_ack   ),
    .irq_req_o      ( irq_req   ),
    .irq_id_o       ( irq_id    ),
    .eoc_o          ( eoc       ),
    .fetch_enable_o ( fetch_en  ),
    .boot_addr_o    ( boot_addr ),
    .busy_o         ( busy      )
  );

  // ************************************************************************
  // checking and bus helpers
  // ************************************************************************

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("FAIL %s: got 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  // read data of the DMA model depends on the whole address
  function automatic logic [31:0] dma_pattern(logic [11:0] addr);
    return {addr, 8'hA5, ~addr};
  endfunction

  // called right after a falling edge; returns 1 ns after one
  task automatic bus_access(input logic [11:0] addr, input logic [31:0] wdata,
                            input logic rd, input logic [3:0] id,
                            output logic [31:0] rdata);
    int lat;
    bus_req.req   = 1'b1;
    bus_req.addr  = addr;
    bus_req.wen   = rd;
    bus_req.wdata = wdata;
    bus_req.be    = 4'hf;
    bus_req.id    = id;
    #1;
    while (!bus_rsp.gnt) begin
      @(negedge clk);
      #1;
    end
    @(negedge clk);
    bus_req.req = 1'b0;
    #1;
    lat = 1;
    while (!bus_rsp.r_valid) begin
      @(negedge clk);
      #1;
      lat++;
    end
    check_value("bus_rsp_o.r_id", bus_rsp.r_id, id);
    if (addr[11:10] != TGT_DMA) begin
      check_value("r_valid latency", lat, 1);
    end
    rdata = bus_rsp.r_rdata;
  endtask

  task automatic pulse_event(input logic [11:0] src, input logic [31:0] cores);
    if (src == 12'h1) begin
      dma_evt = 1'b1;
    end else begin
      hwpe_evt = cores[NB_CORES-1:0];
    end
    @(negedge clk);
    dma_evt  = 1'b0;
    hwpe_evt = '0;
  endtask

  task automatic wait_irq(input int core, input logic [31:0] exp_id);
    int n;
    n = 0;
    #1;
    while (!irq_req[core] && n < IRQ_WAIT_MAX) begin
      @(negedge clk);
      #1;
      n++;
    end
    if (!irq_req[core]) begin
      n_errors++;
      $display("no interrupt request on core %0d within %0d cycles", core, IRQ_WAIT_MAX);
    end else begin
      check_value($sformatf("irq_id_o[%0d]", core), irq_id[core], exp_id);
    end
  endtask

  // four-phase ack where the request must fall after one cycle and stay low
  task automatic ack_irq(input int core);
    int lat;
    #1;
    check_value($sformatf("irq_req_o[%0d] before ack", core), irq_req[core], 1);
    @(negedge clk);
    irq_ack[core] = 1'b1;
    #1;
    lat = 0;
    while (irq_req[core] && lat < IRQ_WAIT_MAX) begin
      @(negedge clk);
      #1;
      lat++;
    end
    check_value("irq ack to drop latency", lat, 1);
    repeat (2) begin
      @(negedge clk);
      #1;
      check_value($sformatf("irq_req_o[%0d] during ack", core), irq_req[core], 0);
    end
    @(negedge clk);
    irq_ack[core] = 1'b0;
  endtask

  task automatic check_output(input logic [11:0] sel, input logic [31:0] exp);
    #1;
    case (sel)
      12'h0:   check_value("eoc_o", eoc, exp);
      12'h1:   check_value("fetch_enable_o", fetch_en, exp);
      12'h2:   check_value("irq_req_o", irq_req, exp);
      12'h3:   check_value("busy_o", busy, exp);
      default: check_value($sformatf("boot_addr_o[%0d]", sel[1:0]), boot_addr[sel[1:0]], exp);
    endcase
  endtask

  task automatic run_record(input int idx);
    logic [31:0] rdata;
    logic [3:0]  id;
    id = 4'(idx);
    case (rec_op[idx])
      "w": bus_access(rec_addr[idx], rec_data[idx], 1'b0, id, rdata);
      "r": begin
        bus_access(rec_addr[idx], '0, 1'b1, id, rdata);
        check_value($sformatf("r_rdata at 0x%03h", rec_addr[idx]), rdata, rec_exp[idx]);
      end
      "l": begin
        // let the counter run well past the bound before reading it
        repeat (2 * rec_exp[idx]) @(negedge clk);
        bus_access(rec_addr[idx], '0, 1'b1, id, rdata);
        check_value("r_rdata below bound", rdata < rec_exp[idx], 1);
      end
      "e": pulse_event(rec_addr[idx], rec_data[idx]);
      "i": wait_irq(int'(rec_addr[idx]), rec_data[idx]);
      "a": ack_irq(int'(rec_addr[idx]));
      "o": check_output(rec_addr[idx], rec_exp[idx]);
      "n": repeat (rec_data[idx]) @(negedge clk);
      default: begin
        n_errors++;
        $display("record %0d has an unknown operation", idx);
      end
    endcase
  endtask

  // ************************************************************************
  // DMA port model
  // ************************************************************************

  // grants after 0 to 3 cycles, answers one cycle after the grant
  initial begin : dma_responder
    logic        granted;
    periph_req_t seen;
    int          wait_cyc;
    dma_rsp  = '0;
    granted  = 1'b0;
    seen     = '0;
    wait_cyc = 0;
    forever begin
      @(negedge clk);
      dma_rsp.r_valid = 1'b0;
      if (granted) begin
        dma_rsp.r_valid = 1'b1;
        dma_rsp.r_id    = seen.id;
        dma_rsp.r_rdata = seen.wen ? dma_pattern(seen.addr) : '0;
        wait_cyc        = $unsigned($random(seed)) % 4;
      end else if (seen.req && wait_cyc > 0) begin
        wait_cyc--;
      end
      dma_rsp.gnt = (wait_cyc == 0);
      #1;
      seen    = dma_req;
      granted = dma_req.req && dma_rsp.gnt;
      if (granted) begin
        check_value("dma_req_o", seen, bus_req);
      end
    end
  end

  // ************************************************************************
  // main sequence
  // ************************************************************************

  initial begin : main
    int          fd;
    int          n;
    string       line;
    logic [7:0]  op;
    logic [31:0] a;
    logic [31:0] d;
    logic [31:0] e;
    bus_req  = '0;
    dma_evt  = 1'b0;
    hwpe_evt = '0;
    irq_ack  = '0;
    fd = $fopen("verif/cluster_periph_testdata.txt", "r");
    if (fd == 0) begin
      n_errors++;
      $display("cannot open the test data file");
    end else begin
      while (!$feof(fd)) begin
        line = "";
        n = $fgets(line, fd);
        if (line.len() > 1 && line[0] != "#") begin
          n = $sscanf(line, "%c %h %h %h", op, a, d, e);
          if (n == 4) begin
            rec_op.push_back(op);
            rec_addr.push_back(a[11:0]);
            rec_data.push_back(d);
            rec_exp.push_back(e);
          end
        end
      end
      $fclose(fd);
    end
    if (rec_op.size() == 0) begin
      n_errors++;
      $display("no test records were loaded");
    end
    load_done = 1'b1;
    @(posedge rst_n);
    for (int i = 0; i < rec_op.size(); i++) begin
      @(negedge clk);
      run_record(i);
    end
    repeat (4) @(negedge clk);
    $display("checks: %0d, errors: %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

  initial begin : watchdog
    wait (load_done);
    repeat (rec_op.size() * CYC_PER_REC + 100) @(posedge clk);
    $display("timeout: the test sequence did not finish in time");
    $display("checks: %0d, errors: %0d", n_checks, n_errors + 1);
    $display("Some tests failed");
    $finish;
  end

endmodule

`default_nettype wire
